/* logic/videoTxPkg.sv */
// Raster constants, pixel and bus structs and address helpers shared by the TFT transmit path
`default_nettype none

package videoTxPkg;

	//------------------------------------------------------------
	// Raster timing, small panel for short simulations
	//------------------------------------------------------------
	localparam int lpHActive    = 16;
	localparam int lpVActive    = 8;
	localparam int lpHTotal     = 24;
	localparam int lpVTotal     = 12;
	// Sync pulses sit inside the blanking intervals
	localparam int lpHSyncStart = 18;
	localparam int lpHSyncEnd   = 21;
	localparam int lpVSyncStart = 9;
	localparam int lpVSyncEnd   = 10;

	// Counter and coordinate widths
	localparam int lpHCntWidth  = $clog2(lpHTotal);
	localparam int lpVCntWidth  = $clog2(lpVTotal);
	localparam int lpXWidth     = $clog2(lpHActive);
	localparam int lpYWidth     = $clog2(lpVActive);

	//------------------------------------------------------------
	// Frame buffer geometry
	//------------------------------------------------------------
	localparam int lpLanes        = 4;
	localparam int lpLaneWidth    = $clog2(lpLanes);
	localparam int lpWordsPerLine = lpHActive / lpLanes;
	localparam int lpBufWords     = lpWordsPerLine * lpVActive;
	localparam int lpBufAdrsWidth = $clog2(lpBufWords);

	// Sync generator to TFT pins, matches RAM read plus word register
	localparam int lpAlignLatency = 2;

	// RGB444 pixel
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb444_t;

	// Four pixels per buffer word, lane 0 in the low bits
	typedef rgb444_t [lpLanes-1:0] bufWord_t;

	// Host pixel write
	typedef struct packed {
		logic [lpXWidth-1:0] x;
		logic [lpYWidth-1:0] y;
		rgb444_t             color;
	} hostWr_t;

	// RAM access, zero mask is a read
	typedef struct packed {
		logic [lpBufAdrsWidth-1:0] adrs;
		logic [lpLanes-1:0]        mask;
		bufWord_t                  data;
	} bufReq_t;

	typedef struct packed {
		logic hSync;
		logic vSync;
		logic de;
	} rasterSync_t;

	// TFT pin bundle
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		logic       hSync;
		logic       vSync;
		logic       de;
		logic       backLight;
	} tftOut_t;

	// Word address of a pixel, y * words per line + x / lanes
	function automatic logic [lpBufAdrsWidth-1:0] wordAdrs(
		input logic [lpXWidth-1:0] x,
		input logic [lpYWidth-1:0] y
	);
		return lpBufAdrsWidth'(y * lpWordsPerLine + x / lpLanes);
	endfunction

	// Lane of a pixel inside its word
	function automatic logic [lpLaneWidth-1:0] laneOf(input logic [lpXWidth-1:0] x);
		return lpLaneWidth'(x % lpLanes);
	endfunction

endpackage

`default_nettype wire

/* logic/pipeDelay.sv */
// Fixed-length delay line for any packed payload, used to align syncs and lane tags
`timescale 1ns/1ps
`default_nettype none

module pipeDelay #(
	parameter type payload_t = logic,
	parameter int  pLength   = 2
) (
	input  logic     iVideoClk,
	input  logic     arstN,
	input  payload_t din,
	output payload_t dout
);

	// Stage 0 takes din
	payload_t stage [pLength];

	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < pLength; i++)
				stage[i] <= '0;
		end
		else
		begin
			stage[0] <= din;
			for (int i = 1; i < pLength; i++)
				stage[i] <= stage[i-1];
		end
	end

	assign dout = stage[pLength-1];

endmodule

`default_nettype wire

/* logic/videoSyncGen.sv */
// Raster timing generator, instantiated once in the transmit top to drive scanout and the TFT syncs
`timescale 1ns/1ps
`default_nettype none

module videoSyncGen (
	input  logic                                iVideoClk,
	input  logic                                arstN,
	output videoTxPkg::rasterSync_t             sync,
	output logic [videoTxPkg::lpXWidth-1:0]     x,
	output logic [videoTxPkg::lpYWidth-1:0]     y
);
	import videoTxPkg::*;

	logic [lpHCntWidth-1:0] hCnt;
	logic [lpVCntWidth-1:0] vCnt;
	logic                   hActive;
	logic                   vActive;
	logic                   hSyncNow;
	logic                   vSyncNow;

	//------------------------------------------------------------
	// Column and line counters
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (hCnt == lpHCntWidth'(lpHTotal - 1))
		begin
			hCnt <= '0;
			// Line wrap, then frame wrap
			if (vCnt == lpVCntWidth'(lpVTotal - 1))
				vCnt <= '0;
			else
				vCnt <= vCnt + 1'b1;
		end
		else
			hCnt <= hCnt + 1'b1;
	end

	// Decode from the current count
	always_comb
	begin
		hActive  = hCnt < lpHCntWidth'(lpHActive);
		vActive  = vCnt < lpVCntWidth'(lpVActive);
		hSyncNow = (hCnt >= lpHCntWidth'(lpHSyncStart)) && (hCnt < lpHCntWidth'(lpHSyncEnd));
		vSyncNow = (vCnt >= lpVCntWidth'(lpVSyncStart)) && (vCnt < lpVCntWidth'(lpVSyncEnd));
	end

	//------------------------------------------------------------
	// Registered outputs, one cycle behind the counters
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			sync <= '0;
			x    <= '0;
			y    <= '0;
		end
		else
		begin
			sync.hSync <= hSyncNow;
			sync.vSync <= vSyncNow;
			sync.de    <= hActive && vActive;
			// Coordinates only meaningful while active, zero elsewhere
			x <= hActive ? lpXWidth'(hCnt) : '0;
			y <= vActive ? lpYWidth'(vCnt) : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/frameBufRam.sv */
// Single-port frame buffer with per-lane write enables, driven by the buffer arbiter
`timescale 1ns/1ps
`default_nettype none

module frameBufRam (
	input  logic                 iVideoClk,
	input  videoTxPkg::bufReq_t  req,
	input  logic                 en,
	output videoTxPkg::bufWord_t rdWord
);
	import videoTxPkg::*;

	// Word storage
	bufWord_t mem [lpBufWords];

	always_ff @(posedge iVideoClk)
	begin
		if (en)
		begin
			// Mask zero means read
			if (req.mask == '0)
				rdWord <= mem[req.adrs];
			else
			begin
				for (int i = 0; i < lpLanes; i++)
				begin
					// Untouched lanes keep their pixel
					if (req.mask[i])
						mem[req.adrs][i] <= req.data[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/frameBufArbiter.sv */
// Fixed-priority arbiter for the frame buffer, scanout reads first and one held host write
`timescale 1ns/1ps
`default_nettype none

module frameBufArbiter (
	input  logic                                   iVideoClk,
	input  logic                                   arstN,
	input  logic                                   rdStb,
	input  logic [videoTxPkg::lpBufAdrsWidth-1:0]  rdAdrs,
	output videoTxPkg::bufWord_t                   rdWord,
	input  logic                                   wrStb,
	input  videoTxPkg::bufReq_t                    wrReq
);
	import videoTxPkg::*;

	bufReq_t ramReq;
	logic    ramEn;
	bufReq_t pendReq;
	logic    pendValid;
	logic    pendLoad;

	//------------------------------------------------------------
	// Request select
	//------------------------------------------------------------
	always_comb
	begin
		ramEn  = 1'b0;
		ramReq = '0;
		if (rdStb)
		begin
			// Read wins, zero mask
			ramEn       = 1'b1;
			ramReq.adrs = rdAdrs;
		end
		else if (pendValid)
		begin
			ramEn  = 1'b1;
			ramReq = pendReq;
		end
		else if (wrStb)
		begin
			ramEn  = 1'b1;
			ramReq = wrReq;
		end
	end

	// Write parks when the RAM is busy with a read or the held write
	assign pendLoad = wrStb && (rdStb || pendValid);

	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			pendValid <= 1'b0;
		else
			pendValid <= pendLoad || (pendValid && rdStb);
	end

	// Held write payload
	always_ff @(posedge iVideoClk)
	begin
		if (pendLoad)
			pendReq <= wrReq;
	end

	frameBufRam u_frameBufRam (
		.iVideoClk (iVideoClk),
		.req       (ramReq),
		.en        (ramEn),
		.rdWord    (rdWord)
	);

endmodule

`default_nettype wire

/* logic/hostPixelWriter.sv */
// Turns single-cycle host pixel writes into lane-masked frame buffer writes for the arbiter
`timescale 1ns/1ps
`default_nettype none

module hostPixelWriter (
	input  logic                iVideoClk,
	input  logic                arstN,
	input  logic                hostWrStb,
	input  videoTxPkg::hostWr_t hostWr,
	output logic                wrStb,
	output videoTxPkg::bufReq_t wrReq
);
	import videoTxPkg::*;

	bufReq_t nextReq;

	//------------------------------------------------------------
	// Address, one-hot lane and replicated color
	//------------------------------------------------------------
	always_comb
	begin
		nextReq.adrs = wordAdrs(hostWr.x, hostWr.y);
		nextReq.mask = lpLanes'(1) << laneOf(hostWr.x);
		// Every lane carries the color, mask picks one
		for (int i = 0; i < lpLanes; i++)
			nextReq.data[i] = hostWr.color;
	end

	// Strobe, one cycle after the host
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			wrStb <= 1'b0;
		else
			wrStb <= hostWrStb;
	end

	// Payload only captured on a strobe
	always_ff @(posedge iVideoClk)
	begin
		if (hostWrStb)
			wrReq <= nextReq;
	end

endmodule

`default_nettype wire

/* logic/scanoutReader.sv */
// Fetches buffer words ahead of the raster and picks the lane of each displayed pixel
`timescale 1ns/1ps
`default_nettype none

module scanoutReader (
	input  logic                                   iVideoClk,
	input  logic                                   arstN,
	input  videoTxPkg::rasterSync_t                sync,
	input  logic [videoTxPkg::lpXWidth-1:0]        x,
	input  logic [videoTxPkg::lpYWidth-1:0]        y,
	output logic                                   rdStb,
	output logic [videoTxPkg::lpBufAdrsWidth-1:0]  rdAdrs,
	input  videoTxPkg::bufWord_t                   rdWord,
	output videoTxPkg::rgb444_t                    pixel
);
	import videoTxPkg::*;

	// Lane and de, travelling together to the pixel select
	typedef struct packed {
		logic                   de;
		logic [lpLaneWidth-1:0] lane;
	} laneTag_t;

	laneTag_t tagIn;
	laneTag_t tagOut;
	logic     rdStbD;
	bufWord_t wordReg;

	//------------------------------------------------------------
	// Read request at lane 0 of each active group
	//------------------------------------------------------------
	assign rdStb  = sync.de && (laneOf(x) == '0);
	assign rdAdrs = wordAdrs(x, y);

	// Marks the cycle rdWord is valid
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			rdStbD <= 1'b0;
		else
			rdStbD <= rdStb;
	end

	// Word held for the whole group
	always_ff @(posedge iVideoClk)
	begin
		if (rdStbD)
			wordReg <= rdWord;
	end

	//------------------------------------------------------------
	// Lane select, aligned to the word register
	//------------------------------------------------------------
	assign tagIn.de   = sync.de;
	assign tagIn.lane = laneOf(x);

	pipeDelay #(
		.payload_t (laneTag_t),
		.pLength   (lpAlignLatency)
	) u_laneDelay (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.din       (tagIn),
		.dout      (tagOut)
	);

	// Black during blanking
	assign pixel = tagOut.de ? wordReg[tagOut.lane] : '0;

endmodule

`default_nettype wire

/* logic/backlightPwm.sv */
// Free-running 8-bit PWM for the TFT backlight, duty set by the host
`timescale 1ns/1ps
`default_nettype none

module backlightPwm (
	input  logic       iVideoClk,
	input  logic       arstN,
	input  logic [7:0] duty,
	output logic       pwm
);

	logic [7:0] cnt;

	//------------------------------------------------------------
	// Period counter, wraps every 256 clocks
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// High for duty clocks per period
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			pwm <= 1'b0;
		else
			pwm <= cnt < duty;
	end

endmodule

`default_nettype wire

/* logic/videoTxUnit.sv */
// Top of the TFT transmit path, joins host writes, buffer, scanout, sync alignment and backlight
`timescale 1ns/1ps
`default_nettype none

module videoTxUnit (
	input  logic                iVideoClk,
	input  logic                arstN,
	input  logic                hostWrStb,
	input  videoTxPkg::hostWr_t hostWr,
	input  logic [7:0]          blDuty,
	output videoTxPkg::tftOut_t tft
);
	import videoTxPkg::*;

	rasterSync_t               sync;
	rasterSync_t               syncAligned;
	logic [lpXWidth-1:0]       x;
	logic [lpYWidth-1:0]       y;
	logic                      rdStb;
	logic [lpBufAdrsWidth-1:0] rdAdrs;
	bufWord_t                  rdWord;
	logic                      wrStb;
	bufReq_t                   wrReq;
	rgb444_t                   pixel;
	logic                      backLight;

	//------------------------------------------------------------
	// Raster and scanout
	//------------------------------------------------------------
	videoSyncGen u_videoSyncGen (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.sync      (sync),
		.x         (x),
		.y         (y)
	);

	scanoutReader u_scanoutReader (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.sync      (sync),
		.x         (x),
		.y         (y),
		.rdStb     (rdStb),
		.rdAdrs    (rdAdrs),
		.rdWord    (rdWord),
		.pixel     (pixel)
	);

	// Host side
	hostPixelWriter u_hostPixelWriter (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.hostWrStb (hostWrStb),
		.hostWr    (hostWr),
		.wrStb     (wrStb),
		.wrReq     (wrReq)
	);

	frameBufArbiter u_frameBufArbiter (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.rdStb     (rdStb),
		.rdAdrs    (rdAdrs),
		.rdWord    (rdWord),
		.wrStb     (wrStb),
		.wrReq     (wrReq)
	);

	//------------------------------------------------------------
	// Syncs follow the pixel through read and word register
	//------------------------------------------------------------
	pipeDelay #(
		.payload_t (rasterSync_t),
		.pLength   (lpAlignLatency)
	) u_syncDelay (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.din       (sync),
		.dout      (syncAligned)
	);

	backlightPwm u_backlightPwm (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.duty      (blDuty),
		.pwm       (backLight)
	);

	// Pin bundle
	always_comb
	begin
		tft.r         = pixel.r;
		tft.g         = pixel.g;
		tft.b         = pixel.b;
		tft.hSync     = syncAligned.hSync;
		tft.vSync     = syncAligned.vSync;
		tft.de        = syncAligned.de;
		tft.backLight = backLight;
	end

endmodule

`default_nettype wire

/* verification/videoClkGen.sv */
// Testbench clock and reset source, 40 ns video clock with reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module videoClkGen (
	output logic iVideoClk,
	output logic arstN
);

	localparam int lpHalfPeriodNs = 20;

	// Free-running clock
	initial
	begin
		iVideoClk = 1'b0;
		forever
			#(lpHalfPeriodNs) iVideoClk = ~iVideoClk;
	end

	// Reset low for two rising edges
	initial
	begin
		arstN = 1'b0;
		repeat (2) @(posedge iVideoClk);
		arstN <= 1'b1;
	end

endmodule

`default_nettype wire

/* verification/videoTx_chk.sv */
// Concurrent assertions on the frame buffer arbiter, bound onto every arbiter instance
`timescale 1ns/1ps
`default_nettype none

module videoTx_chk (
	input logic                                  iVideoClk,
	input logic                                  arstN,
	input logic                                  rdStb,
	input logic [videoTxPkg::lpBufAdrsWidth-1:0] rdAdrs,
	input videoTxPkg::bufWord_t                  rdWord,
	input logic                                  wrStb,
	input logic                                  ramEn,
	input videoTxPkg::bufReq_t                   ramReq,
	input logic                                  pendValid
);
	import videoTxPkg::*;

	// Count of failed assertions
	int failCount;

	// Reference copy of the buffer, built from the RAM write requests
	bufWord_t shadowMem [lpBufWords];
	bufWord_t shadowWord;

	initial
		failCount = 0;

	always @(posedge iVideoClk)
	begin
		if (ramEn && (ramReq.mask != '0))
		begin
			for (int i = 0; i < lpLanes; i++)
			begin
				if (ramReq.mask[i])
					shadowMem[ramReq.adrs][i] <= ramReq.data[i];
			end
		end
	end

	assign shadowWord = shadowMem[rdAdrs];

	//------------------------------------------------------------
	// Read path
	//------------------------------------------------------------
	// Word at rdAdrs shows up on rdWord exactly one cycle after the strobe
	aReadPath: assert property (@(posedge iVideoClk) disable iff (!arstN)
		rdStb |=> (rdWord === $past(shadowWord)))
	else
	begin
		failCount++;
		$error("rdWord one cycle after the read strobe did not hold the addressed word");
	end

	//------------------------------------------------------------
	// Held write
	//------------------------------------------------------------
	aPendDrain: assert property (@(posedge iVideoClk) disable iff (!arstN)
		$rose(pendValid) |-> ##[1:2] !pendValid)
	else
	begin
		failCount++;
		$error("Held write still pending after two cycles");
	end

	// Write that meets a read gets the RAM alone on the next cycle
	aHeldWriteOut: assert property (@(posedge iVideoClk) disable iff (!arstN)
		(rdStb && wrStb) |=> (ramEn && !rdStb && (ramReq.mask != '0)))
	else
	begin
		failCount++;
		$error("Write colliding with a read did not reach the RAM on its own next cycle");
	end

	// New write on top of a held one while a read is busy would be lost
	aNoLostWrite: assert property (@(posedge iVideoClk) disable iff (!arstN)
		(pendValid && wrStb) |-> !rdStb)
	else
	begin
		failCount++;
		$error("Write arrived while a held write and a read were both pending");
	end

endmodule

bind frameBufArbiter videoTx_chk u_videoTxChk (
	.iVideoClk (iVideoClk),
	.arstN     (arstN),
	.rdStb     (rdStb),
	.rdAdrs    (rdAdrs),
	.rdWord    (rdWord),
	.wrStb     (wrStb),
	.ramEn     (ramEn),
	.ramReq    (ramReq),
	.pendValid (pendValid)
);

`default_nettype wire

/* verification/videoTxTb.sv */
// Top-level testbench for the TFT transmit path, random host writes checked against a pixel model
`timescale 1ns/1ps
`default_nettype none

module videoTxTb;
	import videoTxPkg::*;

	localparam int lpClkNs      = 40;
	localparam int lpFrameClks  = lpHTotal * lpVTotal;
	localparam int lpWatchdogNs = (6 * lpFrameClks + 200) * lpClkNs;
	// Write window after the vSync edge, well ahead of the first active pixel
	localparam int lpBurstClks  = 40;
	localparam int lpCheckFrames = 4;

	logic       iVideoClk;
	logic       arstN;
	logic       hostWrStb;
	hostWr_t    hostWr;
	logic [7:0] blDuty;
	tftOut_t    tft;

	// Expected picture, one entry per pixel
	rgb444_t model [lpVActive][lpHActive];
	logic    checkOn;
	logic    hsSeen;
	tftOut_t prevTft;
	int      xCnt;
	int      yCnt;
	int      vsCount;
	int      hsPerFrame;
	int      lineCycles;
	int      hsWidth;
	int      pixelChecks;

	videoClkGen u_videoClkGen (
		.iVideoClk (iVideoClk),
		.arstN     (arstN)
	);

	videoTxUnit i_videoTxUnit (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.hostWrStb (hostWrStb),
		.hostWr    (hostWr),
		.blDuty    (blDuty),
		.tft       (tft)
	);

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	//------------------------------------------------------------
	// Host side stimulus
	//------------------------------------------------------------
	// Called on a rising edge, leaves gap cycles to the next strobe
	task automatic issueWrite(input logic [lpXWidth-1:0] x, input logic [lpYWidth-1:0] y,
		input rgb444_t color, input int gap);
		hostWr_t wr;
		wr.x       = x;
		wr.y       = y;
		wr.color   = color;
		hostWr    <= wr;
		hostWrStb <= 1'b1;
		model[y][x] = color;
		@(posedge iVideoClk);
		hostWrStb <= 1'b0;
		repeat (gap - 1) @(posedge iVideoClk);
	endtask

	// Every pixel to black
	task automatic clearBuffer();
		for (int y = 0; y < lpVActive; y++)
			for (int x = 0; x < lpHActive; x++)
				issueWrite(lpXWidth'(x), lpYWidth'(y), '0, 2);
	endtask

	// All four lanes of one word, then one lane again
	task automatic writeNeighbours();
		issueWrite(4'd4, 3'd3, rgb444_t'(12'h123), 2);
		issueWrite(4'd5, 3'd3, rgb444_t'(12'h456), 2);
		issueWrite(4'd6, 3'd3, rgb444_t'(12'h789), 2);
		issueWrite(4'd7, 3'd3, rgb444_t'(12'habc), 2);
		issueWrite(4'd6, 3'd3, rgb444_t'(12'hf0e), 3);
		issueWrite(4'd15, 3'd7, rgb444_t'(12'h5a5), 2);
	endtask

	task automatic randomBurst();
		int used;
		int gap;
		used = 0;
		while (used + 5 <= lpBurstClks)
		begin
			gap = 2 + $urandom_range(3);
			issueWrite(lpXWidth'($urandom_range(lpHActive - 1)),
				lpYWidth'($urandom_range(lpVActive - 1)), rgb444_t'(12'($urandom)), gap);
			used += gap;
		end
	endtask

	// Returns on the rising edge after tft.vSync goes high
	task automatic waitVSyncRise();
		logic prevVs;
		@(negedge iVideoClk);
		prevVs = tft.vSync;
		@(negedge iVideoClk);
		while (!(tft.vSync && !prevVs))
		begin
			prevVs = tft.vSync;
			@(negedge iVideoClk);
		end
		@(posedge iVideoClk);
	endtask

	// One full PWM period after the new duty has settled
	task automatic checkBacklight();
		logic [7:0] duty;
		int         highCnt;
		duty    = 8'($urandom);
		highCnt = 0;
		blDuty <= duty;
		@(posedge iVideoClk);
		repeat (256)
		begin
			@(negedge iVideoClk);
			if (tft.backLight)
				highCnt++;
		end
		checkValue("tft.backLight high count", highCnt, duty);
	endtask

	//------------------------------------------------------------
	// Output monitor, sampled on the falling edge
	//------------------------------------------------------------
	always @(negedge iVideoClk)
	begin
		if (arstN)
		begin
			// Frame boundary
			if (tft.vSync && !prevTft.vSync)
			begin
				if (vsCount > 0)
				begin
					checkValue("tft.hSync pulses per frame", hsPerFrame, lpVTotal);
					checkValue("tft.de lines per frame", yCnt, lpVActive);
				end
				vsCount++;
				hsPerFrame = 0;
				yCnt       = 0;
			end
			// Line boundary
			if (tft.hSync && !prevTft.hSync)
			begin
				if (hsSeen)
					checkValue("tft.hSync period", lineCycles, lpHTotal);
				hsSeen     = 1'b1;
				lineCycles = 0;
				hsWidth    = 0;
				hsPerFrame++;
			end
			lineCycles++;
			if (tft.hSync)
				hsWidth++;
			if (!tft.hSync && prevTft.hSync)
				checkValue("tft.hSync width", hsWidth, lpHSyncEnd - lpHSyncStart);
			// Pixel position from de pulse counting
			if (tft.de)
			begin
				if (checkOn)
				begin
					checkValue("tft.rgb", {tft.r, tft.g, tft.b}, model[yCnt][xCnt]);
					pixelChecks++;
				end
				xCnt++;
			end
			else
				checkValue("tft.rgb while de low", {tft.r, tft.g, tft.b}, 0);
			if (!tft.de && prevTft.de)
			begin
				checkValue("tft.de pixels per line", xCnt, lpHActive);
				xCnt = 0;
				yCnt++;
			end
			prevTft = tft;
		end
	end

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial
	begin
		void'($urandom(32'h16ff_4f3b));
		hostWrStb   = 1'b0;
		hostWr      = '0;
		blDuty      = '0;
		checkOn     = 1'b0;
		hsSeen      = 1'b0;
		prevTft     = '0;
		xCnt        = 0;
		yCnt        = 0;
		vsCount     = 0;
		hsPerFrame  = 0;
		lineCycles  = 0;
		hsWidth     = 0;
		pixelChecks = 0;
		for (int y = 0; y < lpVActive; y++)
			for (int x = 0; x < lpHActive; x++)
				model[y][x] = '0;
		wait (arstN === 1'b1);
		@(posedge iVideoClk);
		// Unchecked setup frames
		clearBuffer();
		writeNeighbours();
		// Writes in vertical blanking, next frame checked
		repeat (lpCheckFrames)
		begin
			waitVSyncRise();
			checkOn = 1'b1;
			fork
				randomBurst();
				checkBacklight();
			join
		end
		waitVSyncRise();
		checkValue("checked pixel count", pixelChecks, lpCheckFrames * lpHActive * lpVActive);
		if (i_videoTxUnit.u_frameBufArbiter.u_videoTxChk.failCount == 0)
			$display("STATUS: PASS");
		else
		begin
			$display("Arbiter assertions failed during the run");
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		#(lpWatchdogNs);
		$display("Timeout: the run did not finish within %0d ns", lpWatchdogNs);
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

/* flist.f */
logic/videoTxPkg.sv
logic/pipeDelay.sv
logic/videoSyncGen.sv
logic/frameBufRam.sv
logic/frameBufArbiter.sv
logic/hostPixelWriter.sv
logic/scanoutReader.sv
logic/backlightPwm.sv
logic/videoTxUnit.sv
verification/videoClkGen.sv
verification/videoTx_chk.sv
verification/videoTxTb.sv
